// ==== design/sram_pkg.sv ====
package sram_pkg;

  // default geometry of the bank array
  // the top level overrides these through its own parameters

  // number of independent sram chips
  localparam int DEFAULT_NUM_BANKS = 4;

  // word address width inside one chip
  localparam int DEFAULT_BANK_ADDR_BITS = 16;

  // width of one data word on the chip pins
  localparam int DEFAULT_DATA_BITS = 16;

  // per-bank controller sequence
  // idle     waiting for a request, ready is high
  // reading  oe_n cycle in progress, ready is low
  // writing  we_n cycle in progress, ready is low
  // each active state lasts exactly one clock
  typedef enum logic [1:0] {
    state_idle    = 2'd0,
    state_reading = 2'd1,
    state_writing = 2'd2
  } ctrl_state_t;

endpackage

// ==== design/sram_req_if.sv ====
`timescale 1ns/1ns

// one bank's request/response channel
interface sram_req_if
  import sram_pkg::*;
#(
  parameter int BANK_ADDR_BITS = DEFAULT_BANK_ADDR_BITS,
  parameter int DATA_BITS      = DEFAULT_DATA_BITS
);

  // clock and reset fanned out to the bank by the router
  logic                      clk;
  logic                      reset;

  // request side, driven by the router
  logic                      req;
  logic                      write_enable;
  logic [BANK_ADDR_BITS-1:0] addr;
  logic [DATA_BITS-1:0]      write_data;

  // response side, driven by the controller
  // ready is a level, rd_valid a single-cycle pulse
  logic                      ready;
  logic                      rd_valid;
  logic [DATA_BITS-1:0]      rd_data;

  modport router (
    output clk, reset, req, write_enable, addr, write_data,
    input  ready
  );

  modport ctrl (
    input  clk, reset, req, write_enable, addr, write_data,
    output ready, rd_valid, rd_data
  );

  // read-only tap on the read return
  modport collector (
    input rd_valid, rd_data
  );

endinterface

// ==== design/bank_router.sv ====
`timescale 1ns/1ns

module bank_router
  import sram_pkg::*;
#(
  parameter int NUM_BANKS       = DEFAULT_NUM_BANKS,
  parameter int BANK_ADDR_BITS  = DEFAULT_BANK_ADDR_BITS,
  parameter int DATA_BITS       = DEFAULT_DATA_BITS,
  localparam int SEL_BITS       = $clog2(NUM_BANKS),
  localparam int SEL_SPAN       = 1 << SEL_BITS,
  localparam int ADDR_BITS      = SEL_BITS + BANK_ADDR_BITS
) (
  input  logic                 clk,
  input  logic                 reset,

  // caller side
  input  logic                 req,
  input  logic                 write_enable,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [DATA_BITS-1:0] write_data,
  output logic                 ready,

  // one channel per bank
  sram_req_if.router           bank [NUM_BANKS]
);

  // bank field is the top of the address, the rest goes to the chip
  logic [SEL_BITS-1:0]       bank_sel;
  logic [BANK_ADDR_BITS-1:0] local_addr;

  // ready of every selectable bank, padded to a power of two
  logic [SEL_SPAN-1:0]       bank_ready;

  assign bank_sel   = addr[ADDR_BITS-1 -: SEL_BITS];
  assign local_addr = addr[BANK_ADDR_BITS-1:0];

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    // every bank runs off the same clock and reset
    assign bank[i].clk   = clk;
    assign bank[i].reset = reset;

    // only the addressed bank sees req
    assign bank[i].req = req && (bank_sel == SEL_BITS'(i));

    // address, direction and data are broadcast
    // the other banks ignore them while their req is low
    assign bank[i].write_enable = write_enable;
    assign bank[i].addr         = local_addr;
    assign bank[i].write_data   = write_data;

    assign bank_ready[i] = bank[i].ready;
  end

  // bank numbers past NUM_BANKS never accept
  for (genvar i = NUM_BANKS; i < SEL_SPAN; i++) begin : g_absent
    assign bank_ready[i] = 1'b0;
  end

  // caller sees the addressed bank's ready
  // a busy bank does not hold off requests to the others
  assign ready = bank_ready[bank_sel];

endmodule

// ==== design/sram_controller.sv ====
`timescale 1ns/1ns

module sram_controller
  import sram_pkg::*;
#(
  parameter int BANK_ADDR_BITS = DEFAULT_BANK_ADDR_BITS,
  parameter int DATA_BITS      = DEFAULT_DATA_BITS
) (
  input  logic                      clk,
  input  logic                      reset,

  // request channel from the router, read return to the collector
  sram_req_if.ctrl                  host,

  // chip pins, data bus split into out/enable/in
  output logic [BANK_ADDR_BITS-1:0] sram_addr,
  output logic [DATA_BITS-1:0]      sram_dq_out,
  output logic                      sram_dq_oe,
  output logic                      sram_we_n,
  output logic                      sram_oe_n,
  input  logic [DATA_BITS-1:0]      sram_dq_in
);

  // access sequence, edge 0 is the accepting rising edge
  //   edge 0   register addr and data, enter reading or writing
  //   fall 0   drop we_n or oe_n
  //   edge 1   back to idle, ready again
  //   fall 1   raise the strobe, read data captured here
  //   edge 2   rd_valid pulse
  // the strobe sits half a clock inside the address window on both sides

  ctrl_state_t               state;
  logic                      accept;

  // address and write data held for the whole access
  logic [BANK_ADDR_BITS-1:0] addr_reg;
  logic [DATA_BITS-1:0]      wdata_reg;

  // read was in flight last cycle, data is captured by now
  logic                      rd_pending;

  // only idle takes a new request
  assign host.ready = (state == state_idle);
  assign accept     = host.req && host.ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      case (state)
        state_idle: begin
          if (host.req) begin
            state <= host.write_enable ? state_writing : state_reading;
          end
        end
        // both access states are a single cycle
        default: begin
          state <= state_idle;
        end
      endcase
    end
  end

  // payload registers, loaded on acceptance only
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_reg  <= host.addr;
      wdata_reg <= host.write_data;
    end
  end

  assign sram_addr   = addr_reg;
  assign sram_dq_out = wdata_reg;

  // drive the bus from acceptance until we_n is back high
  // the low we_n keeps it on past edge 1 up to fall 1
  assign sram_dq_oe = (state == state_writing) || !sram_we_n;

  // strobes change on the falling edge only
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      sram_we_n <= (state != state_writing);
      sram_oe_n <= (state != state_reading);
    end
  end

  // sample the chip on the edge that ends oe_n
  always_ff @(negedge clk) begin
    if (!sram_oe_n) begin
      host.rd_data <= sram_dq_in;
    end
  end

  // two-stage delay from the reading state to the rd_valid pulse
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rd_pending    <= 1'b0;
      host.rd_valid <= 1'b0;
    end else begin
      rd_pending    <= (state == state_reading);
      host.rd_valid <= rd_pending;
    end
  end

endmodule

// ==== design/read_collector.sv ====
`timescale 1ns/1ns

module read_collector
  import sram_pkg::*;
#(
  parameter int NUM_BANKS = DEFAULT_NUM_BANKS,
  parameter int DATA_BITS = DEFAULT_DATA_BITS
) (
  input  logic                 clk,
  input  logic                 reset,

  // read return of every bank
  sram_req_if.collector        bank [NUM_BANKS],

  // merged, registered read return
  output logic                 read_valid,
  output logic [DATA_BITS-1:0] read_data
);

  // flattened copies of the per-bank returns
  logic [NUM_BANKS-1:0] bank_valid;
  logic [DATA_BITS-1:0] bank_data [NUM_BANKS];

  logic                 any_valid;
  logic [DATA_BITS-1:0] merged_data;

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    assign bank_valid[i] = bank[i].rd_valid;
    assign bank_data[i]  = bank[i].rd_data;
  end

  assign any_valid = |bank_valid;

  // and-or mux, valid is one-hot or zero
  // fixed bank latency and one acceptance per cycle keep it that way
  always_comb begin
    merged_data = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      merged_data = merged_data | (bank_data[i] & {DATA_BITS{bank_valid[i]}});
    end
  end

  // one register stage, read return lands on edge 3
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      read_valid <= 1'b0;
      read_data  <= '0;
    end else begin
      read_valid <= any_valid;
      // hold the last word between returns
      if (any_valid) begin
        read_data <= merged_data;
      end
    end
  end

endmodule

// ==== design/sram_bank_array.sv ====
`timescale 1ns/1ns

module sram_bank_array
  import sram_pkg::*;
#(
  parameter int NUM_BANKS      = DEFAULT_NUM_BANKS,
  parameter int BANK_ADDR_BITS = DEFAULT_BANK_ADDR_BITS,
  parameter int DATA_BITS      = DEFAULT_DATA_BITS,
  // bank number on top, chip word address below
  localparam int ADDR_BITS     = $clog2(NUM_BANKS) + BANK_ADDR_BITS
) (
  input  logic                      clk,
  input  logic                      reset,

  // caller side
  input  logic                      req,
  input  logic                      write_enable,
  input  logic [ADDR_BITS-1:0]      addr,
  input  logic [DATA_BITS-1:0]      write_data,
  output logic                      ready,
  output logic                      read_valid,
  output logic [DATA_BITS-1:0]      read_data,

  // one set of chip pins per bank
  output logic [BANK_ADDR_BITS-1:0] sram_addr   [NUM_BANKS],
  output logic [DATA_BITS-1:0]      sram_dq_out [NUM_BANKS],
  output logic                      sram_dq_oe  [NUM_BANKS],
  input  logic [DATA_BITS-1:0]      sram_dq_in  [NUM_BANKS],
  output logic                      sram_we_n   [NUM_BANKS],
  output logic                      sram_oe_n   [NUM_BANKS]
);

  // request/response channel of each bank
  sram_req_if #(
    .BANK_ADDR_BITS(BANK_ADDR_BITS),
    .DATA_BITS     (DATA_BITS)
  ) bank_if [NUM_BANKS] ();

  // address decode and ready select
  bank_router #(
    .NUM_BANKS     (NUM_BANKS),
    .BANK_ADDR_BITS(BANK_ADDR_BITS),
    .DATA_BITS     (DATA_BITS)
  ) u_router (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .write_enable(write_enable),
    .addr        (addr),
    .write_data  (write_data),
    .ready       (ready),
    .bank        (bank_if)
  );

  // one sequencer per chip, clocked through its channel
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    sram_controller #(
      .BANK_ADDR_BITS(BANK_ADDR_BITS),
      .DATA_BITS     (DATA_BITS)
    ) u_ctrl (
      .clk        (bank_if[i].clk),
      .reset      (bank_if[i].reset),
      .host       (bank_if[i]),
      .sram_addr  (sram_addr[i]),
      .sram_dq_out(sram_dq_out[i]),
      .sram_dq_oe (sram_dq_oe[i]),
      .sram_we_n  (sram_we_n[i]),
      .sram_oe_n  (sram_oe_n[i]),
      .sram_dq_in (sram_dq_in[i])
    );
  end

  // merge of the per-bank read returns
  read_collector #(
    .NUM_BANKS(NUM_BANKS),
    .DATA_BITS(DATA_BITS)
  ) u_collector (
    .clk       (clk),
    .reset     (reset),
    .bank      (bank_if),
    .read_valid(read_valid),
    .read_data (read_data)
  );

endmodule

// ==== bench/sram_chip_model.sv ====
`timescale 1ns/1ns

// behavioral asynchronous sram, one per bank
// data bus split into in/enable/out as on the controller side
module sram_chip_model #(
  parameter int ADDR_BITS = 16,
  parameter int DATA_BITS = 16
) (
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [DATA_BITS-1:0] dq_in,
  input  logic                 dq_oe,
  input  logic                 we_n,
  input  logic                 oe_n,
  output logic [DATA_BITS-1:0] dq_out
);

  // storage starts unknown, nothing is cleared
  logic [DATA_BITS-1:0] mem [1 << ADDR_BITS];

  // set once we_n has really been low
  // keeps the power-up x to 1 step on we_n from writing
  logic                 we_low;

  // bus driven by the controller when we_n fell
  logic                 bus_driven;

  initial begin
    we_low     = 1'b0;
    bus_driven = 1'b0;
  end

  always @(negedge we_n) begin
    we_low     = 1'b1;
    bus_driven = (dq_oe === 1'b1);
  end

  // write latched on the rising edge of we_n
  // a floating bus leaves the word unknown
  always @(posedge we_n) begin
    if (we_low) begin
      mem[addr] <= bus_driven ? dq_in : 'x;
      we_low = 1'b0;
    end
  end

  // output enabled only while oe_n is low
  assign dq_out = (oe_n === 1'b0) ? mem[addr] : 'x;

endmodule

// ==== bench/tb_sram_bank_array.sv ====
`timescale 1ns/1ns

module tb_sram_bank_array
  import sram_pkg::*;
;
  localparam int NUM_BANKS      = DEFAULT_NUM_BANKS;
  localparam int BANK_ADDR_BITS = DEFAULT_BANK_ADDR_BITS;
  localparam int DATA_BITS      = DEFAULT_DATA_BITS;
  localparam int SEL_BITS       = $clog2(NUM_BANKS);
  localparam int ADDR_BITS      = SEL_BITS + BANK_ADDR_BITS;
  localparam int PERIOD         = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int NUM_OPS        = 300;
  // local addresses used per bank
  localparam int WINDOW         = 16;
  localparam int TOTAL_OPS      = NUM_BANKS * WINDOW + NUM_OPS;
  localparam int TIMEOUT        = RESET_CYCLES + 4 * TOTAL_OPS + 100;
  localparam logic [31:0] SEED  = 32'hc92d6168;

  logic clk, reset, req, write_enable, ready, read_valid;
  logic [ADDR_BITS-1:0]      addr;
  logic [DATA_BITS-1:0]      write_data, read_data;
  logic [BANK_ADDR_BITS-1:0] sram_addr   [NUM_BANKS];
  logic [DATA_BITS-1:0]      sram_dq_out [NUM_BANKS];
  logic [DATA_BITS-1:0]      sram_dq_in  [NUM_BANKS];
  logic                      sram_dq_oe  [NUM_BANKS];
  logic                      sram_we_n   [NUM_BANKS];
  logic                      sram_oe_n   [NUM_BANKS];

  // reference memory and expected read returns
  logic [DATA_BITS-1:0] ref_mem [logic [ADDR_BITS-1:0]];
  logic [DATA_BITS-1:0] exp_data [$];
  int unsigned          exp_stamp [$];
  int unsigned          cycle;
  // bank accepted at the last edge, split by direction
  logic [NUM_BANKS-1:0] busy_write, busy_read;
  logic                 started, overlap_seen;
  time                  last_clk_fall;
  logic [SEL_BITS-1:0]  cur_sel;

  assign cur_sel = addr[ADDR_BITS-1 -: SEL_BITS];

  sram_bank_array #(
    .NUM_BANKS(NUM_BANKS), .BANK_ADDR_BITS(BANK_ADDR_BITS), .DATA_BITS(DATA_BITS)
  ) DUT (
    .clk(clk), .reset(reset), .req(req), .write_enable(write_enable), .addr(addr),
    .write_data(write_data), .ready(ready), .read_valid(read_valid),
    .read_data(read_data), .sram_addr(sram_addr), .sram_dq_out(sram_dq_out),
    .sram_dq_oe(sram_dq_oe), .sram_dq_in(sram_dq_in), .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  // fill word mixes every address bit
  function automatic logic [DATA_BITS-1:0] fill_word(input logic [ADDR_BITS-1:0] a);
    return DATA_BITS'((32'(a) * 32'h9e3779b1) >> 11);
  endfunction

  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_chip
    logic [BANK_ADDR_BITS-1:0] cap_addr;
    logic [DATA_BITS-1:0]      cap_data;
    time                       fall_t;

    sram_chip_model #(.ADDR_BITS(BANK_ADDR_BITS), .DATA_BITS(DATA_BITS)) u_chip (
      .addr(sram_addr[i]), .dq_in(sram_dq_out[i]), .dq_oe(sram_dq_oe[i]),
      .we_n(sram_we_n[i]), .oe_n(sram_oe_n[i]), .dq_out(sram_dq_in[i])
    );

    // strobe falls on a clock fall, and only in the bank just written
    always @(negedge sram_we_n[i]) begin
      fall_t   = $time;
      cap_addr = sram_addr[i];
      cap_data = sram_dq_out[i];
      a_we_fall: assert (!reset && fall_t == last_clk_fall && busy_write[i])
        else fail_run($sformatf("we_n of bank %0d fell off a clock fall or unrequested", i));
    end

    always @(posedge sram_we_n[i]) begin
      if (!reset) begin
        a_we_width: assert ($time - fall_t == PERIOD)
          else fail_run($sformatf("mismatch we_n low time bank %0d: %h expected %h",
                                  i, $time - fall_t, PERIOD));
      end
    end

    always @(negedge sram_oe_n[i]) begin
      a_oe_fall: assert (!reset && busy_read[i])
        else fail_run($sformatf("oe_n of bank %0d fell with no read issued", i));
    end

    a_no_we_oe: assert property (@(posedge clk) disable iff (reset)
      sram_we_n[i] || sram_oe_n[i])
      else fail_run($sformatf("we_n and oe_n low together in bank %0d", i));
    a_no_fight: assert property (@(posedge clk) disable iff (reset)
      !(sram_dq_oe[i] && !sram_oe_n[i]))
      else fail_run($sformatf("bank %0d drives dq while the chip drives it", i));

    // sampled at the fall that ends the strobe, after the mid-window rising edge
    a_we_oe: assert property (@(negedge clk) disable iff (reset)
      sram_we_n[i] || sram_dq_oe[i])
      else fail_run($sformatf("mismatch sram_dq_oe bank %0d: 0 expected 1", i));
    a_we_addr: assert property (@(negedge clk) disable iff (reset)
      sram_we_n[i] || sram_addr[i] == cap_addr)
      else fail_run($sformatf("mismatch sram_addr bank %0d: %h expected %h",
                              i, sram_addr[i], cap_addr));
    a_we_data: assert property (@(negedge clk) disable iff (reset)
      sram_we_n[i] || sram_dq_out[i] == cap_data)
      else fail_run($sformatf("mismatch sram_dq_out bank %0d: %h expected %h",
                              i, sram_dq_out[i], cap_data));
  end

  // caller ready follows the addressed bank's busy cycle
  a_ready: assert property (@(posedge clk) disable iff (reset)
    ready == !(busy_write[cur_sel] || busy_read[cur_sel]))
    else fail_run($sformatf("mismatch ready: %h expected %h", ready,
                            !(busy_write[cur_sel] || busy_read[cur_sel])));

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // clock falls, overlap of banks in flight
  always @(negedge clk) begin
    int active;
    last_clk_fall = $time;
    active = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (busy_write[b] || busy_read[b] || !sram_we_n[b] || !sram_oe_n[b]) active++;
    end
    if (active > 1) overlap_seen = 1'b1;
  end

  // reference model, read return check, reset state, timeout
  always @(posedge clk) begin
    logic accept;
    accept = !reset && req && ready;
    for (int b = 0; b < NUM_BANKS; b++) begin
      busy_write[b] <= accept && cur_sel == SEL_BITS'(b) && write_enable;
      busy_read[b]  <= accept && cur_sel == SEL_BITS'(b) && !write_enable;
    end
    if (!reset && !started) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        a_reset_pins: assert (sram_we_n[b] && sram_oe_n[b] && !sram_dq_oe[b])
          else fail_run($sformatf("bank %0d strobes active before any request", b));
      end
      a_reset_out: assert (ready && !read_valid)
        else fail_run($sformatf("mismatch ready/read_valid after reset: %h/%h expected 1/0",
                                ready, read_valid));
    end
    if (!reset && read_valid) begin
      a_outstanding: assert (exp_data.size() != 0)
        else fail_run("read_valid with no read outstanding");
      // registered at edge 3, seen by the following sampling edge
      a_latency: assert (cycle == exp_stamp[0] + 4)
        else fail_run($sformatf("mismatch read latency: %h expected %h",
                                cycle - exp_stamp[0], 4));
      a_read_data: assert (read_data == exp_data[0])
        else fail_run($sformatf("mismatch read_data: %h expected %h",
                                read_data, exp_data[0]));
      void'(exp_data.pop_front());
      void'(exp_stamp.pop_front());
    end
    if (accept && write_enable) begin
      ref_mem[addr] = write_data;
    end else if (accept) begin
      a_known: assert (ref_mem.exists(addr))
        else fail_run($sformatf("read of unwritten address %h", addr));
      exp_data.push_back(ref_mem[addr]);
      exp_stamp.push_back(cycle);
    end
    cycle = cycle + 1;
    if (cycle >= TIMEOUT) begin
      fail_run($sformatf("timeout after %0d cycles, bank 0 state %s",
                         cycle, DUT.g_bank[0].u_ctrl.state.name()));
    end
  end

  // hold the request from a clock fall until it is accepted
  task automatic issue(input logic we, input logic [ADDR_BITS-1:0] a,
                       input logic [DATA_BITS-1:0] d);
    @(negedge clk);
    started      = 1'b1;
    req          = 1'b1;
    write_enable = we;
    addr         = a;
    write_data   = d;
    @(posedge clk);
    while (!ready) @(posedge clk);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    req = 1'b0;
    @(posedge clk);
  endtask

  initial begin
    int bank, prev_bank, la;
    logic [ADDR_BITS-1:0] a;
    void'($urandom(SEED));
    reset = 1'b1;
    req = 1'b0;
    write_enable = 1'b0;
    addr = '0;
    write_data = '0;
    cycle = 0;
    started = 1'b0;
    overlap_seen = 1'b0;
    busy_write = '0;
    busy_read = '0;
    last_clk_fall = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (2) @(posedge clk);
    // same local address, different word in every bank
    for (int l = 0; l < WINDOW; l++) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        a = {SEL_BITS'(b), BANK_ADDR_BITS'(l)};
        issue(1'b1, a, fill_word(a));
      end
    end
    prev_bank = 0;
    for (int n = 0; n < NUM_OPS; n++) begin
      bank = $urandom_range(NUM_BANKS - 1);
      la   = $urandom_range(WINDOW - 1);
      // bursts force a new bank every cycle
      if ((n % 16) < 8) begin
        if (bank == prev_bank) bank = (bank + 1) % NUM_BANKS;
      end else if ($urandom_range(3) == 0) begin
        idle_cycle();
      end
      a = {SEL_BITS'(bank), BANK_ADDR_BITS'(la)};
      issue(1'($urandom_range(1)), a, DATA_BITS'($urandom));
      prev_bank = bank;
    end
    idle_cycle();
    while (exp_data.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    a_overlap: assert (overlap_seen) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      fail_run("no two banks were ever in flight together");
    end
  end

endmodule

// ==== tb.f ====
design/sram_pkg.sv
design/sram_req_if.sv
design/bank_router.sv
design/sram_controller.sv
design/read_collector.sv
design/sram_bank_array.sv
bench/sram_chip_model.sv
bench/tb_sram_bank_array.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sram_bank_array
RTL_TOP   ?= sram_bank_array
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) design/sram_pkg.sv \
		design/sram_req_if.sv design/bank_router.sv design/sram_controller.sv \
		design/read_collector.sv design/sram_bank_array.sv

clean:
	rm -rf $(OBJ_DIR)
